// File: sim/corePatterns.txt
// Program: word count, then one instruction word per line (hex)
// Expected writes: count, then rd and value per line in program order (hex)
00000016
123450B7  // 00 lui   x1, 0x12345
00500113  // 04 addi  x2, x0, 5
00710193  // 08 addi  x3, x2, 7
40218233  // 0C sub   x4, x3, x2
002242B3  // 10 xor   x5, x4, x2
00001317  // 14 auipc x6, 1
00102423  // 18 sw    x1, 8(x0)
00802383  // 1C lw    x7, 8(x0)
4043D413  // 20 srai  x8, x7, 4
003224B3  // 24 slt   x9, x4, x3
00310463  // 28 beq   x2, x3, +8 not taken
00311663  // 2C bne   x2, x3, +12 taken
00100513  // 30 addi  x10, x0, 1 wrong path
00200593  // 34 addi  x11, x0, 2 wrong path
0080066F  // 38 jal   x12, +8
00300693  // 3C addi  x13, x0, 3 wrong path
00C60767  // 40 jalr  x14, 12(x12)
00400793  // 44 addi  x15, x0, 4 wrong path
00C70833  // 48 add   x16, x14, x12
0000006F  // 4C jal   x0, 0 self-loop
00000013  // 50 nop
00000013  // 54 nop
0000000C
01 12345000  // x1
02 00000005  // x2
03 0000000C  // x3
04 00000007  // x4
05 00000002  // x5
06 00001014  // x6
07 12345000  // x7
08 01234500  // x8
09 00000001  // x9
0C 0000003C  // x12
0E 00000044  // x14
10 00000080  // x16

// File: src.f
common/coreRrvPkg.sv
src/coreRrvCtrl.sv
src/coreRrvFetch.sv
src/coreRrvRegFile.sv
src/coreRrvExe.sv
src/coreRrvMem.sv
src/coreRrvTop.sv
sim/coreRrvTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module coreRrvTb -Mdir "$BUILD_DIR" -o coreRrvSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/coreRrvSim" > "$LOG_FILE" 2>&1
SIM_STATUS=$?
cat "$LOG_FILE"
if [ $SIM_STATUS -ne 0 ]; then
    echo "Simulation exited with status $SIM_STATUS"
    exit 1
fi

if grep -q "^Test OK$" "$LOG_FILE"; then
    exit 0
fi
exit 1

// File: sim/coreRrvTb.sv
//------------------------------------------------
// Testbench of the RV32I core
// Program load from the pattern file during reset
// Register write trace checked in order
// Second run with random data memory freeze
//------------------------------------------------
`timescale 1ns/1ps

module coreRrvTb
    import coreRrvPkg::*;
();

    localparam string       PatFile        = "sim/corePatterns.txt";
    localparam int          PatDepth       = 256;
    localparam int          ClockPeriod    = 8;
    localparam int          ResetCycles    = 4;
    localparam int          CyclesPerWrite = 40;
    localparam int          IdleCycles     = 50;
    localparam int          NumRuns        = 2;
    localparam logic [31:0] LcgSeed        = 32'd37;

    logic   Clock;
    logic   rstN;
    logic   IMemWrEn;
    tPc     IMemWrAddr;
    tWord   IMemWrData;
    logic   DMemReady;
    logic   RegWrEnQ105H;
    tRegIdx RegDstQ105H;
    tWord   RegWrDataQ105H;

    tWord        Pat [PatDepth];
    int          ProgLen;
    int          ExpLen;
    int          ExpBase;       // First rd word of the expected list
    int          WrCount;       // Writes seen since the last reset
    logic        RandFreeze;
    logic [31:0] LcgState;

    coreRrvTop coreRrvTop_i (.*);

    initial begin
        Clock = 1'b0;
        forever #(ClockPeriod / 2) Clock = ~Clock;
    end

    //------------------------------------------------
    // Helpers
    //------------------------------------------------
    function automatic logic [31:0] lcgNext(input logic [31:0] State);
        return State * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic tWord patWord(input int Pos);
        return Pat[Pos[7:0]];
    endfunction

    task automatic abortRun();
        $display("Test FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // One cycle, inputs change on the falling edge
    task automatic stepCycle();
        @(negedge Clock);
        if (RandFreeze) begin
            LcgState  = lcgNext(LcgState);
            DMemReady = (LcgState[31:30] != 2'b00);     // Low about one cycle in four
        end else begin
            DMemReady = 1'b1;
        end
    endtask

    task automatic checkWrite(input int Idx, input tRegIdx Dst, input tWord Data);
        tRegIdx ExpDst;
        tWord   ExpData;
        assert (Idx < ExpLen) else begin
            $display("Extra register write to x%0d after all %0d expected writes", Dst, ExpLen);
            abortRun();
        end
        ExpDst  = tRegIdx'(patWord(ExpBase + 2 * Idx));
        ExpData = patWord(ExpBase + 2 * Idx + 1);
        assert (Dst == ExpDst) else begin
            $display("** Error at %0t: write %0d went to x%0d, expected x%0d",
                     $time, Idx, Dst, ExpDst);
            abortRun();
        end
        assert (Data == ExpData) else begin
            $display("** Error at %0t: write %0d to x%0d is %h, expected %h",
                     $time, Idx, Dst, Data, ExpData);
            abortRun();
        end
    endtask

    task automatic runProgram(input logic Freeze);
        RandFreeze = 1'b0;
        stepCycle();
        rstN = 1'b0;
        for (int i = 0; i < ProgLen; i++) begin
            IMemWrEn   = 1'b1;
            IMemWrAddr = tPc'(i) << 2;
            IMemWrData = patWord(i + 1);
            stepCycle();
        end
        IMemWrEn = 1'b0;
        repeat (ResetCycles) stepCycle();           // Reset held past the program load
        rstN       = 1'b1;
        RandFreeze = Freeze;
        while (WrCount < ExpLen)
            stepCycle();
        // Core sits in its self-loop now
        repeat (IdleCycles) stepCycle();
    endtask

    //------------------------------------------------
    // Trace monitor and watchdog
    //------------------------------------------------
    always @(posedge Clock) begin
        if (!rstN) begin
            WrCount = 0;
        end else begin
            assert (!(RegWrEnQ105H && !DMemReady)) else begin
                $display("** Error at %0t: write to x%0d while DMemReady is low",
                         $time, RegDstQ105H);
                abortRun();
            end
            if (RegWrEnQ105H) begin
                checkWrite(WrCount, RegDstQ105H, RegWrDataQ105H);
                WrCount = WrCount + 1;
            end
        end
    end

    initial begin : watchdog
        int LimitCycles;
        @(posedge Clock);
        LimitCycles = NumRuns * (ProgLen + ResetCycles + ExpLen * CyclesPerWrite
                                 + IdleCycles + 2);
        repeat (LimitCycles) @(posedge Clock);
        $display("Timeout: register writes stopped, %0d of %0d seen in this run after %0d cycles",
                 WrCount, ExpLen, LimitCycles);
        abortRun();
    end

    initial begin
        rstN       = 1'b0;
        IMemWrEn   = 1'b0;
        IMemWrAddr = '0;
        IMemWrData = '0;
        DMemReady  = 1'b1;
        RandFreeze = 1'b0;
        LcgState   = LcgSeed;
        $readmemh(PatFile, Pat);
        ProgLen = int'(Pat[0]);
        ExpLen  = int'(patWord(ProgLen + 1));
        ExpBase = ProgLen + 2;
        assert (ProgLen > 0 && ExpLen > 0) else begin
            $display("Pattern file %s holds no program or no expected writes", PatFile);
            abortRun();
        end
        runProgram(1'b0);
        runProgram(1'b1);       // Same trace expected under random freeze
        $display("Test OK");
        $finish;
    end

endmodule

// File: src/coreRrvTop.sv
//------------------------------------------------
// Core top level
// Control plus fetch, register file,
// execute and memory datapath
//------------------------------------------------
`timescale 1ns/1ps

module coreRrvTop
    import coreRrvPkg::*;
(
    input  logic   Clock,
    input  logic   rstN,
    input  logic   IMemWrEn,
    input  tPc     IMemWrAddr,
    input  tWord   IMemWrData,
    input  logic   DMemReady,
    output logic   RegWrEnQ105H,
    output tRegIdx RegDstQ105H,
    output tWord   RegWrDataQ105H
);

    logic ReadyQ100H, ReadyQ101H, ReadyQ102H, ReadyQ103H, ReadyQ104H, ReadyQ105H;
    logic BranchCondMetQ102H, SelNextPcAluOutQ102H;
    tPc      PcQ101H, Pc4Q103H;
    tWord    PreInstructionQ101H, ImmediateQ101H, RegData1Q101H, RegData2Q101H;
    tWord    AluOutQ102H, AluOutQ103H, AluOutQ104H, StoreDataQ103H, MemDataQ104H;
    tRegIdx  RegSrc1Q101H, RegSrc2Q101H;
    tCtrlExe CtrlExe;
    tCtrlMem CtrlMem;
    tCtrlWb  CtrlWb;

    // Write trace
    assign RegWrEnQ105H = CtrlWb.RegWrEnQ105H;
    assign RegDstQ105H  = CtrlWb.RegDstQ105H;

    coreRrvCtrl coreRrvCtrl_i (.*);

    coreRrvFetch coreRrvFetch_i (.*);

    coreRrvRegFile coreRrvRegFile_i (.*);

    coreRrvExe coreRrvExe_i (.*);

    coreRrvMem coreRrvMem_i (.*);

endmodule

// File: src/coreRrvMem.sv
//------------------------------------------------
// Memory and write back
// Data memory, load data register,
// write-back select in Q105H
//------------------------------------------------
`timescale 1ns/1ps

module coreRrvMem
    import coreRrvPkg::*;
(
    input  logic    Clock,
    input  logic    ReadyQ104H,
    input  logic    ReadyQ105H,
    input  tCtrlMem CtrlMem,
    input  tCtrlWb  CtrlWb,
    input  tWord    AluOutQ103H,
    input  tWord    StoreDataQ103H,
    input  tPc      Pc4Q103H,
    input  tWord    AluOutQ104H,
    output tWord    MemDataQ104H,
    output tWord    RegWrDataQ105H
);

    tWord DMem [DMemDepth];
    tPc   Pc4Q104H, Pc4Q105H;
    tWord AluOutQ105H, MemDataQ105H;

    always_ff @(posedge Clock) begin
        if (ReadyQ104H) begin
            if (CtrlMem.DMemWrEnQ103H)
                DMem[AluOutQ103H[9:2]] <= StoreDataQ103H;
            if (CtrlMem.DMemRdEnQ103H)
                MemDataQ104H <= DMem[AluOutQ103H[9:2]];
            Pc4Q104H <= Pc4Q103H;
        end
        if (ReadyQ105H) begin
            AluOutQ105H  <= AluOutQ104H;
            MemDataQ105H <= MemDataQ104H;
            Pc4Q105H     <= Pc4Q104H;
        end
    end

    always_comb begin
        case (CtrlWb.SelWrBackQ105H)
            WbDMem:  RegWrDataQ105H = MemDataQ105H;
            WbPc4:   RegWrDataQ105H = Pc4Q105H;
            default: RegWrDataQ105H = AluOutQ105H;
        endcase
    end

    aNoRdWr: assert property (@(posedge Clock)
        !(CtrlMem.DMemWrEnQ103H && CtrlMem.DMemRdEnQ103H));

endmodule

// File: src/coreRrvExe.sv
//------------------------------------------------
// Execute stage
// Operand forwarding and select, ALU,
// branch condition, Q102H to Q104H data pipe
//------------------------------------------------
`timescale 1ns/1ps

module coreRrvExe
    import coreRrvPkg::*;
(
    input  logic    Clock,
    input  logic    ReadyQ102H,
    input  logic    ReadyQ103H,
    input  logic    ReadyQ104H,
    input  tCtrlExe CtrlExe,
    input  tPc      PcQ101H,
    input  tWord    ImmediateQ101H,
    input  tWord    RegData1Q101H,
    input  tWord    RegData2Q101H,
    input  tWord    RegWrDataQ105H,
    input  tWord    MemDataQ104H,
    output tWord    AluOutQ102H,
    output logic    BranchCondMetQ102H,
    output tWord    AluOutQ103H,
    output tWord    StoreDataQ103H,
    output tPc      Pc4Q103H,
    output tWord    AluOutQ104H
);

    tPc   PcQ102H;
    tWord ImmediateQ102H, RegData1Q102H, RegData2Q102H;
    tWord Src1Q102H, Src2Q102H, AluInA, AluInB, AluRes;
    logic CondMet;

    always_ff @(posedge Clock) begin
        if (ReadyQ102H) begin
            PcQ102H        <= PcQ101H;
            ImmediateQ102H <= ImmediateQ101H;
            RegData1Q102H  <= RegData1Q101H;
            RegData2Q102H  <= RegData2Q101H;
        end
    end

    // Youngest writer wins
    function automatic tWord fwdOperand(input tRegIdx Src, input tWord RfData);
        if (CtrlExe.RegWrEnQ103H && Src == CtrlExe.RegDstQ103H)
            return AluOutQ103H;
        if (CtrlExe.RegWrEnQ104H && Src == CtrlExe.RegDstQ104H)
            return CtrlExe.DMemRdEnQ104H ? MemDataQ104H : AluOutQ104H;
        if (CtrlExe.RegWrEnQ105H && Src == CtrlExe.RegDstQ105H)
            return RegWrDataQ105H;
        return RfData;
    endfunction

    always_comb begin
        Src1Q102H = fwdOperand(CtrlExe.RegSrc1Q102H, RegData1Q102H);
        Src2Q102H = fwdOperand(CtrlExe.RegSrc2Q102H, RegData2Q102H);
        AluInA    = CtrlExe.SelAluPcQ102H  ? PcQ102H        : Src1Q102H;
        AluInB    = CtrlExe.SelAluImmQ102H ? ImmediateQ102H : Src2Q102H;
        case (CtrlExe.AluOpQ102H)
            SUB:     AluRes = AluInA - AluInB;
            SLL:     AluRes = AluInA << AluInB[4:0];
            SLT:     AluRes = {31'b0, $signed(AluInA) < $signed(AluInB)};
            SLTU:    AluRes = {31'b0, AluInA < AluInB};
            XOR:     AluRes = AluInA ^ AluInB;
            SRL:     AluRes = AluInA >> AluInB[4:0];
            SRA:     AluRes = tWord'($signed(AluInA) >>> AluInB[4:0]);
            OR:      AluRes = AluInA | AluInB;
            AND:     AluRes = AluInA & AluInB;
            default: AluRes = AluInA + AluInB;
        endcase
        case (CtrlExe.BranchOpQ102H)
            BEQ:     CondMet = (Src1Q102H == Src2Q102H);
            BNE:     CondMet = (Src1Q102H != Src2Q102H);
            BLT:     CondMet = ($signed(Src1Q102H) <  $signed(Src2Q102H));
            BGE:     CondMet = ($signed(Src1Q102H) >= $signed(Src2Q102H));
            BLTU:    CondMet = (Src1Q102H <  Src2Q102H);
            BGEU:    CondMet = (Src1Q102H >= Src2Q102H);
            default: CondMet = 1'b0;
        endcase
    end

    // LUI passes the immediate, jump targets drop bit 0 (JALR)
    assign AluOutQ102H = CtrlExe.LuiQ102H ? AluInB :
                         {AluRes[31:1], AluRes[0] && !CtrlExe.SelNextPcAluOutJQ102H};
    assign BranchCondMetQ102H = CtrlExe.SelNextPcAluOutBQ102H && CondMet;

    always_ff @(posedge Clock) begin
        if (ReadyQ103H) begin
            // Jumps carry the link value onward so forwarding sees it
            AluOutQ103H    <= CtrlExe.SelNextPcAluOutJQ102H ? PcQ102H + 32'd4 : AluOutQ102H;
            StoreDataQ103H <= Src2Q102H;
            Pc4Q103H       <= PcQ102H + 32'd4;
        end
        if (ReadyQ104H)
            AluOutQ104H <= AluOutQ103H;
    end

endmodule

// File: src/coreRrvRegFile.sv
//------------------------------------------------
// Register file, 32 x 32
// Two read ports, one write port
// Same-cycle write bypass, x0 reads zero
//------------------------------------------------
`timescale 1ns/1ps

module coreRrvRegFile
    import coreRrvPkg::*;
(
    input  logic   Clock,
    input  tRegIdx RegSrc1Q101H,
    input  tRegIdx RegSrc2Q101H,
    input  tCtrlWb CtrlWb,
    input  tWord   RegWrDataQ105H,
    output tWord   RegData1Q101H,
    output tWord   RegData2Q101H
);

    tWord Regs [32];
    logic WrEn;

    assign WrEn = CtrlWb.RegWrEnQ105H && (CtrlWb.RegDstQ105H != '0);

    always_ff @(posedge Clock) begin
        if (WrEn)
            Regs[CtrlWb.RegDstQ105H] <= RegWrDataQ105H;
    end

    assign RegData1Q101H = (RegSrc1Q101H == '0)                          ? '0 :
                           (WrEn && RegSrc1Q101H == CtrlWb.RegDstQ105H) ? RegWrDataQ105H :
                                                                           Regs[RegSrc1Q101H];
    assign RegData2Q101H = (RegSrc2Q101H == '0)                          ? '0 :
                           (WrEn && RegSrc2Q101H == CtrlWb.RegDstQ105H) ? RegWrDataQ105H :
                                                                           Regs[RegSrc2Q101H];

endmodule

// File: src/coreRrvFetch.sv
//------------------------------------------------
// Fetch stage
// PC register and next-PC select
// Instruction memory with its load port
//------------------------------------------------
`timescale 1ns/1ps

module coreRrvFetch
    import coreRrvPkg::*;
(
    input  logic Clock,
    input  logic rstN,
    input  logic ReadyQ100H,
    input  logic ReadyQ101H,
    input  logic SelNextPcAluOutQ102H,
    input  tPc   AluOutQ102H,
    input  logic IMemWrEn,
    input  tPc   IMemWrAddr,
    input  tWord IMemWrData,
    output tPc   PcQ101H,
    output tWord PreInstructionQ101H
);

    tWord IMem [IMemDepth];
    tPc   PcQ100H;

    always_ff @(posedge Clock) begin
        if (!rstN)
            PcQ100H <= '0;
        else if (ReadyQ100H)
            PcQ100H <= SelNextPcAluOutQ102H ? AluOutQ102H : PcQ100H + 32'd4;
    end

    always_ff @(posedge Clock) begin
        if (IMemWrEn)
            IMem[IMemWrAddr[9:2]] <= IMemWrData;    // Program load while in reset
        if (ReadyQ101H) begin
            PreInstructionQ101H <= IMem[PcQ100H[9:2]];
            PcQ101H             <= PcQ100H;
        end
    end

    aPcAligned: assert property (@(posedge Clock) disable iff (!rstN) PcQ100H[1:0] == 2'b00);

endmodule

// File: src/coreRrvCtrl.sv
//------------------------------------------------
// Core control
// Decode and immediate generation in Q101H
// Load-use stall, redirect flush, stage readies
// Control pipe and valid bits Q102H to Q105H
//------------------------------------------------
`timescale 1ns/1ps

module coreRrvCtrl
    import coreRrvPkg::*;
(
    input  logic          Clock,
    input  logic          rstN,
    input  tWord          PreInstructionQ101H,
    input  tPc            PcQ101H,
    input  logic          BranchCondMetQ102H,
    input  logic          DMemReady,
    output logic          ReadyQ100H,
    output logic          ReadyQ101H,
    output logic          ReadyQ102H,
    output logic          ReadyQ103H,
    output logic          ReadyQ104H,
    output logic          ReadyQ105H,
    output tRegIdx        RegSrc1Q101H,
    output tRegIdx        RegSrc2Q101H,
    output tWord          ImmediateQ101H,
    output logic          SelNextPcAluOutQ102H,
    output var tCtrlExe   CtrlExe,
    output var tCtrlMem   CtrlMem,
    output var tCtrlWb    CtrlWb
);

    typedef struct packed {
        tRegIdx     RegSrc1;
        tRegIdx     RegSrc2;
        tRegIdx     RegDst;
        tAluOp      AluOp;
        tBranchType BranchOp;
        tWbSel      SelWrBack;
        logic       Lui;
        logic       SelAluPc;
        logic       SelAluImm;
        logic       SelNextPcAluOutB;
        logic       SelNextPcAluOutJ;
        logic       RegWrEn;
        logic       DMemWrEn;
        logic       DMemRdEn;
    } tCtrlRec;

    tCtrlRec CtrlQ101H, CtrlQ102H, CtrlQ103H, CtrlQ104H, CtrlQ105H;
    tWord    InstructionQ101H;
    tOpcode  OpcodeQ101H;
    tImmType ImmTypeQ101H;
    logic [2:0] Funct3Q101H;
    logic [6:0] Funct7Q101H;
    logic FetchValidQ101H, FlushQ101H, FlushQ103H, LoadHzrdQ101H, PreValidQ101H;
    logic ValidQ102H, ValidQ103H, ValidQ104H, ValidQ105H;
    logic CoreFreeze;

    assign CoreFreeze = !DMemReady;

    //------------------------------------------------
    // Hazards and flush
    //------------------------------------------------
    // Taken branch or jump, plus the one it flushed a cycle ago
    assign SelNextPcAluOutQ102H = BranchCondMetQ102H || CtrlQ102H.SelNextPcAluOutJ;
    assign FlushQ101H = SelNextPcAluOutQ102H || FlushQ103H;

    always_comb begin
        LoadHzrdQ101H = 1'b0;
        for (int s = 0; s < 2; s++) begin
            tCtrlRec Rec;
            Rec = (s == 0) ? CtrlQ102H : CtrlQ103H;
            if (Rec.DMemRdEn && Rec.RegWrEn &&
                (PreInstructionQ101H[19:15] == Rec.RegDst ||
                 PreInstructionQ101H[24:20] == Rec.RegDst))
                LoadHzrdQ101H = 1'b1;
        end
        LoadHzrdQ101H = LoadHzrdQ101H && !FlushQ101H; // Redirect wins
    end

    assign PreValidQ101H    = FetchValidQ101H && !FlushQ101H && !LoadHzrdQ101H;
    assign InstructionQ101H = PreValidQ101H ? PreInstructionQ101H : NopInstr;

    assign ReadyQ105H = !CoreFreeze;
    assign ReadyQ104H = !CoreFreeze;
    assign ReadyQ103H = !CoreFreeze;
    assign ReadyQ102H = !CoreFreeze;
    assign ReadyQ101H = !CoreFreeze && !LoadHzrdQ101H;
    assign ReadyQ100H = ReadyQ101H;

    //------------------------------------------------
    // Decode
    //------------------------------------------------
    assign OpcodeQ101H  = tOpcode'(InstructionQ101H[6:0]);
    assign Funct3Q101H  = InstructionQ101H[14:12];
    assign Funct7Q101H  = InstructionQ101H[31:25];
    assign RegSrc1Q101H = CtrlQ101H.RegSrc1;
    assign RegSrc2Q101H = CtrlQ101H.RegSrc2;

    always_comb begin
        CtrlQ101H                  = '0;
        CtrlQ101H.RegSrc1          = InstructionQ101H[19:15];
        CtrlQ101H.RegSrc2          = InstructionQ101H[24:20];
        CtrlQ101H.RegDst           = InstructionQ101H[11:7];
        CtrlQ101H.BranchOp         = tBranchType'(Funct3Q101H);
        CtrlQ101H.Lui              = (OpcodeQ101H == LUI);
        CtrlQ101H.SelAluPc         = OpcodeQ101H inside {JAL, BRANCH, AUIPC};
        CtrlQ101H.SelAluImm        = (OpcodeQ101H != R_OP);
        CtrlQ101H.SelNextPcAluOutB = (OpcodeQ101H == BRANCH);
        CtrlQ101H.SelNextPcAluOutJ = OpcodeQ101H inside {JAL, JALR};
        CtrlQ101H.DMemWrEn         = (OpcodeQ101H == STORE);
        CtrlQ101H.DMemRdEn         = (OpcodeQ101H == LOAD);
        // x0 is never a write target from here on
        CtrlQ101H.RegWrEn = (OpcodeQ101H inside {LUI, AUIPC, JAL, JALR, LOAD, I_OP, R_OP})
                            && (InstructionQ101H[11:7] != '0);
        CtrlQ101H.SelWrBack = CtrlQ101H.SelNextPcAluOutJ ? WbPc4 :
                              CtrlQ101H.DMemRdEn         ? WbDMem : WbAlu;
        CtrlQ101H.AluOp = ADD;  // Address and link math
        if (OpcodeQ101H == R_OP || OpcodeQ101H == I_OP) begin
            case (Funct3Q101H)
                3'b000:  CtrlQ101H.AluOp = (OpcodeQ101H == R_OP && Funct7Q101H[5]) ? SUB : ADD;
                3'b001:  CtrlQ101H.AluOp = SLL;
                3'b010:  CtrlQ101H.AluOp = SLT;
                3'b011:  CtrlQ101H.AluOp = SLTU;
                3'b100:  CtrlQ101H.AluOp = XOR;
                3'b101:  CtrlQ101H.AluOp = Funct7Q101H[5] ? SRA : SRL;
                3'b110:  CtrlQ101H.AluOp = OR;
                default: CtrlQ101H.AluOp = AND;
            endcase
        end
    end

    // Immediate generator
    always_comb begin
        case (OpcodeQ101H)
            LUI, AUIPC: ImmTypeQ101H = ImmU;
            JAL:        ImmTypeQ101H = ImmJ;
            BRANCH:     ImmTypeQ101H = ImmB;
            STORE:      ImmTypeQ101H = ImmS;
            default:    ImmTypeQ101H = ImmI;
        endcase
        case (ImmTypeQ101H)
            ImmU:    ImmediateQ101H = {InstructionQ101H[31:12], 12'b0};
            ImmJ:    ImmediateQ101H = {{12{InstructionQ101H[31]}}, InstructionQ101H[19:12],
                                       InstructionQ101H[20], InstructionQ101H[30:21], 1'b0};
            ImmB:    ImmediateQ101H = {{20{InstructionQ101H[31]}}, InstructionQ101H[7],
                                       InstructionQ101H[30:25], InstructionQ101H[11:8], 1'b0};
            ImmS:    ImmediateQ101H = {{20{InstructionQ101H[31]}}, InstructionQ101H[31:25],
                                       InstructionQ101H[11:7]};
            default: ImmediateQ101H = {{20{InstructionQ101H[31]}}, InstructionQ101H[31:20]};
        endcase
    end

    //------------------------------------------------
    // Control pipe
    //------------------------------------------------
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            FetchValidQ101H <= 1'b0;
            FlushQ103H      <= 1'b0;
            {CtrlQ102H, CtrlQ103H, CtrlQ104H, CtrlQ105H} <= '0;
            {ValidQ102H, ValidQ103H, ValidQ104H, ValidQ105H} <= '0;
        end else begin
            if (ReadyQ101H)
                FetchValidQ101H <= 1'b1;        // First fetch after reset landed
            if (ReadyQ102H) begin
                CtrlQ102H  <= CtrlQ101H;
                ValidQ102H <= PreValidQ101H;
            end
            if (ReadyQ103H) begin
                CtrlQ103H  <= CtrlQ102H;
                ValidQ103H <= ValidQ102H;
                FlushQ103H <= SelNextPcAluOutQ102H;
            end
            if (ReadyQ104H) begin
                CtrlQ104H  <= CtrlQ103H;
                ValidQ104H <= ValidQ103H;
            end
            if (ReadyQ105H) begin
                CtrlQ105H  <= CtrlQ104H;
                ValidQ105H <= ValidQ104H;
            end
        end
    end

    always_comb begin
        CtrlExe.RegSrc1Q102H          = CtrlQ102H.RegSrc1;
        CtrlExe.RegSrc2Q102H          = CtrlQ102H.RegSrc2;
        CtrlExe.AluOpQ102H            = CtrlQ102H.AluOp;
        CtrlExe.LuiQ102H              = CtrlQ102H.Lui;
        CtrlExe.BranchOpQ102H         = CtrlQ102H.BranchOp;
        CtrlExe.SelAluPcQ102H         = CtrlQ102H.SelAluPc;
        CtrlExe.SelAluImmQ102H        = CtrlQ102H.SelAluImm;
        CtrlExe.SelNextPcAluOutBQ102H = CtrlQ102H.SelNextPcAluOutB;
        CtrlExe.SelNextPcAluOutJQ102H = CtrlQ102H.SelNextPcAluOutJ;
        CtrlExe.RegDstQ103H           = CtrlQ103H.RegDst;
        CtrlExe.RegWrEnQ103H          = CtrlQ103H.RegWrEn && ValidQ103H;
        CtrlExe.RegDstQ104H           = CtrlQ104H.RegDst;
        CtrlExe.RegWrEnQ104H          = CtrlQ104H.RegWrEn && ValidQ104H;
        CtrlExe.DMemRdEnQ104H         = CtrlQ104H.DMemRdEn;
        CtrlExe.RegDstQ105H           = CtrlQ105H.RegDst;
        CtrlExe.RegWrEnQ105H          = CtrlQ105H.RegWrEn && ValidQ105H;
        CtrlMem.DMemWrEnQ103H         = CtrlQ103H.DMemWrEn && ValidQ103H;
        CtrlMem.DMemRdEnQ103H         = CtrlQ103H.DMemRdEn && ValidQ103H;
        CtrlWb.RegDstQ105H            = CtrlQ105H.RegDst;
        CtrlWb.RegWrEnQ105H           = CtrlQ105H.RegWrEn && ValidQ105H && ReadyQ105H;
        CtrlWb.SelWrBackQ105H         = CtrlQ105H.SelWrBack;
    end

    // Decode keeps x0 out of the write path all the way to Q105H
    aWbNotX0: assert property (@(posedge Clock) disable iff (!rstN)
        CtrlWb.RegWrEnQ105H |-> CtrlWb.RegDstQ105H != '0);
    // The bubble a stall leaves in Q102H never redirects
    aStallNoRedirect: assert property (@(posedge Clock) disable iff (!rstN)
        (DMemReady && !ReadyQ101H) |=> !SelNextPcAluOutQ102H);

endmodule

// File: common/coreRrvPkg.sv
//------------------------------------------------
// Shared definitions of the RV32I core
// Memory sizes and the NOP encoding
// Vector types, opcode and ALU enums
// Control records for execute, memory, write back
//------------------------------------------------
package coreRrvPkg;

    localparam int IMemDepth = 256;
    localparam int DMemDepth = 256;

    typedef logic [31:0] tWord;
    typedef logic [31:0] tPc;
    typedef logic [4:0]  tRegIdx;

    localparam tWord NopInstr = 32'h0000_0013; // ADDI x0, x0, 0

    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        I_OP   = 7'b0010011,
        R_OP   = 7'b0110011
    } tOpcode;

    typedef enum logic [3:0] {ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND} tAluOp;
    typedef enum logic [2:0] {ImmI, ImmS, ImmB, ImmU, ImmJ} tImmType;
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } tBranchType;
    typedef enum logic [1:0] {WbAlu, WbDMem, WbPc4} tWbSel;

    //------------------------------------------------
    // Control records leaving the control pipe
    //------------------------------------------------
    typedef struct packed {
        tRegIdx     RegSrc1Q102H;
        tRegIdx     RegSrc2Q102H;
        tAluOp      AluOpQ102H;
        logic       LuiQ102H;
        tBranchType BranchOpQ102H;
        logic       SelAluPcQ102H;
        logic       SelAluImmQ102H;
        logic       SelNextPcAluOutBQ102H;
        logic       SelNextPcAluOutJQ102H;
        tRegIdx     RegDstQ103H;        // Writers seen by the forwarding muxes
        logic       RegWrEnQ103H;
        tRegIdx     RegDstQ104H;
        logic       RegWrEnQ104H;
        logic       DMemRdEnQ104H;      // Q104H result comes from the load data
        tRegIdx     RegDstQ105H;
        logic       RegWrEnQ105H;
    } tCtrlExe;

    typedef struct packed {
        logic DMemWrEnQ103H;
        logic DMemRdEnQ103H;
    } tCtrlMem;

    typedef struct packed {
        tRegIdx RegDstQ105H;
        logic   RegWrEnQ105H;
        tWbSel  SelWrBackQ105H;
    } tCtrlWb;

endpackage
